/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_board_top -f sim.f \
    -o tb_board_top && ./obj_dir/tb_board_top || exit 1

/* sim.f */
+incdir+sim
source/eth_pkg.sv
source/board_pkg.sv
source/mii_rx.sv
source/frame_filter.sv
source/led_flash.sv
source/io_test_pattern.sv
source/board_top.sv
sim/tb_board_top.sv

/* sim/tb_tasks.svh */
    // Cycles counted from the first edge after rx_dv is driven low
    localparam integer RUN_DELAY    = 3;
    localparam integer LED_FIRST    = 4;
    localparam integer LED_LAST     = LED_FIRST + int'(FLASH_PERIOD) - 1;
    localparam integer WATCH_CYCLES = LED_LAST + 2;
    localparam integer OFF          = -1;   // Window that never opens

    localparam integer  LONG_PREAMBLE  = 15;     // 7 bytes of 55 and the SFD low nibble
    localparam integer  SHORT_PREAMBLE = 1;
    localparam integer  NO_BAD_NIBBLE  = -1;
    localparam nibble_t BAD_NIBBLE     = 4'h7;

    task automatic step_cycle();
        @(posedge clock_125_mhz_0_deg);
        #1;
    endtask

    task automatic drive_nibble(input nibble_t value);
        phy_rx_dv = 1'b1;
        phy_rx    = value;
        step_cycle();
    endtask

    task automatic next_random_byte(output byte_t value);
        int i;
        for (i = 0; i < 8; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value[i] = lfsr_state[0];
        end
    endtask

    // Header of destination, source, type and command, then LFSR filler or cut short
    task automatic make_frame(input mac_addr_t dest, input ethertype_t etype,
                              input byte_t command, input int total_bytes);
        logic [119:0] header;
        byte_t        value;
        int           i;
        header = {dest, SOURCE_MAC, etype, command};
        frame_q.delete();
        for (i = 14; i >= 0; i--) begin
            frame_q.push_back(header[8*i +: 8]);
        end
        while (frame_q.size() < total_bytes) begin
            next_random_byte(value);
            frame_q.push_back(value);
        end
        while (frame_q.size() > total_bytes) begin
            void'(frame_q.pop_back());
        end
    endtask

    task automatic send_frame(input int preamble_nibbles, input int bad_pos,
                              input bit odd_nibble);
        int n;
        for (n = 0; n < preamble_nibbles; n++) begin
            drive_nibble((n == bad_pos) ? BAD_NIBBLE : PREAMBLE_NIBBLE);
        end
        drive_nibble(SFD_NIBBLE);
        foreach (frame_q[i]) begin
            drive_nibble(frame_q[i][3:0]);     // Low nibble first
            drive_nibble(frame_q[i][7:4]);
        end
        if (odd_nibble) begin
            drive_nibble(4'hA);
        end
        phy_rx_dv = 1'b0;
        phy_rx    = '0;
    endtask

    task automatic watch_outputs(input int cycles, input int d2_first, input int d2_last,
                                 input int d3_first, input int d3_last,
                                 input logic run_before, input logic run_after);
        int k;
        for (k = 1; k <= cycles; k++) begin
            step_cycle();
            check_value($sformatf("io_led_d2_o at cycle %0d", k),
                        48'(k >= d2_first && k <= d2_last), 48'(led_d2));
            check_value($sformatf("io_led_d3_o at cycle %0d", k),
                        48'(k >= d3_first && k <= d3_last), 48'(led_d3));
            check_value($sformatf("run_o at cycle %0d", k),
                        48'((k < RUN_DELAY) ? run_before : run_after), 48'(run));
        end
    endtask

/* sim/tb_board_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_board_top
    import eth_pkg::*;
    import board_pkg::*;
();

    localparam mac_addr_t    DUT_MAC        = 48'h001C_C0A2_22DD;
    localparam mac_addr_t    OTHER_MAC      = 48'h001C_C0A2_22DE;
    localparam mac_addr_t    SOURCE_MAC     = 48'h0200_0000_0001;
    localparam ethertype_t   IPV4_ETHERTYPE = 16'h0800;
    localparam flash_count_t FLASH_PERIOD   = 32'd40;
    localparam integer       COUNT_WIDTH    = 8;
    localparam integer       RESET_CYCLES   = 10;
    localparam integer       TIMEOUT_CYCLES = 4000;    // Roughly four times the full sequence
    localparam logic [15:0]  LFSR_SEED      = 16'd58769;
    localparam logic [7:0]   PATTERN_START  = 8'hAA;

    logic        clock_125_mhz_0_deg;
    logic        rst;
    logic        phy_rx_dv;
    nibble_t     phy_rx;
    logic        led_d2;
    logic        led_d3;
    logic        run;
    logic        adc_sda;
    logic        adc_sda_oe;
    logic        sda1;
    logic        sda1_oe;
    logic        sda2;
    logic        sda2_oe;
    string       test_name;
    byte_t       frame_q[$];    // Bytes after the SFD
    logic [15:0] lfsr_state;
    integer      cycle_count;

    board_top #(
        .MAC_ADDR     (DUT_MAC),
        .FLASH_PERIOD (FLASH_PERIOD),
        .COUNT_WIDTH  (COUNT_WIDTH)
    ) dut (
        .clock_125_mhz_0_deg (clock_125_mhz_0_deg),
        .rst_i               (rst),
        .phy_rx_dv_i         (phy_rx_dv),
        .phy_rx_i            (phy_rx),
        .io_led_d2_o         (led_d2),
        .io_led_d3_o         (led_d3),
        .run_o               (run),
        .io_adc_sda_o        (adc_sda),
        .io_adc_sda_oe_o     (adc_sda_oe),
        .clk_sda1_o          (sda1),
        .clk_sda1_oe_o       (sda1_oe),
        .io_sda2_o           (sda2),
        .io_sda2_oe_o        (sda2_oe)
    );

    initial begin
        clock_125_mhz_0_deg = 1'b0;
        forever #4 clock_125_mhz_0_deg = ~clock_125_mhz_0_deg;   // 8 ns period
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clock_125_mhz_0_deg);
            cycle_count = cycle_count + 1;
        end
        $display("Test failures found");
        $fatal(1, "Timeout after %0d cycles, the test sequence did not finish", TIMEOUT_CYCLES);
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    task automatic check_value(input string what, input logic [47:0] expected,
                               input logic [47:0] actual);
        assert (actual === expected) else begin
            $display("mismatch in %s: %s expected %0h actual %0h",
                     test_name, what, expected, actual);
            $display("Test failures found");
            $fatal(1, "Stopping at the first error");
        end
    endtask

    `include "tb_tasks.svh"

    task automatic check_reset_state();
        logic [COUNT_WIDTH-1:0] model;
        int k;
        test_name = "reset_state";
        model = PATTERN_START;
        for (k = 0; k < 64; k++) begin
            check_value("io_led_d2_o", 48'(1'b0), 48'(led_d2));
            check_value("io_led_d3_o", 48'(1'b0), 48'(led_d3));
            check_value("run_o", 48'(1'b0), 48'(run));
            check_value($sformatf("open-drain lines at cycle %0d", k),
                48'({model[COUNT_WIDTH-2], model[COUNT_WIDTH-3], model[COUNT_WIDTH-3],
                     model[COUNT_WIDTH-4], model[COUNT_WIDTH-4], model[COUNT_WIDTH-5]}),
                48'({adc_sda_oe, adc_sda, sda1_oe, sda1, sda2_oe, sda2}));
            step_cycle();
            model = model + 1'b1;
        end
    endtask

    task automatic check_matching_frame();
        test_name = "matching_frame";
        make_frame(DUT_MAC, IPV4_ETHERTYPE, 8'h00, 20);
        send_frame(LONG_PREAMBLE, NO_BAD_NIBBLE, 1'b0);
        watch_outputs(WATCH_CYCLES, LED_FIRST, LED_LAST, OFF, OFF, 1'b0, 1'b0);
    endtask

    task automatic check_rejected_frames();
        test_name = "other_mac";
        make_frame(OTHER_MAC, IPV4_ETHERTYPE, 8'h00, 20);
        send_frame(LONG_PREAMBLE, NO_BAD_NIBBLE, 1'b0);
        watch_outputs(WATCH_CYCLES, OFF, OFF, OFF, OFF, 1'b0, 1'b0);
        test_name = "short_frame";
        make_frame(DUT_MAC, IPV4_ETHERTYPE, 8'h00, 12);
        send_frame(LONG_PREAMBLE, NO_BAD_NIBBLE, 1'b0);
        watch_outputs(WATCH_CYCLES, OFF, OFF, OFF, OFF, 1'b0, 1'b0);
        test_name = "bad_preamble";
        make_frame(DUT_MAC, IPV4_ETHERTYPE, 8'h00, 20);
        send_frame(LONG_PREAMBLE, 6, 1'b0);
        watch_outputs(WATCH_CYCLES, OFF, OFF, OFF, OFF, 1'b0, 1'b0);
    endtask

    task automatic check_run_control();
        test_name = "run_set";
        make_frame(DUT_MAC, RUN_ETHERTYPE, 8'h01, 20);
        send_frame(LONG_PREAMBLE, NO_BAD_NIBBLE, 1'b0);
        watch_outputs(WATCH_CYCLES, LED_FIRST, LED_LAST, LED_FIRST, LED_LAST, 1'b0, 1'b1);
        test_name = "run_clear";
        make_frame(DUT_MAC, RUN_ETHERTYPE, 8'h00, 20);
        send_frame(LONG_PREAMBLE, NO_BAD_NIBBLE, 1'b0);
        watch_outputs(WATCH_CYCLES, LED_FIRST, LED_LAST, OFF, OFF, 1'b1, 1'b0);
    endtask

    task automatic check_flash_restart();
        test_name = "flash_restart";
        make_frame(DUT_MAC, IPV4_ETHERTYPE, 8'h00, 20);
        send_frame(LONG_PREAMBLE, NO_BAD_NIBBLE, 1'b0);
        watch_outputs(LED_FIRST, LED_FIRST, LED_LAST, OFF, OFF, 1'b0, 1'b0);
        // Short preamble so the second match lands while d2 is still lit
        make_frame(DUT_MAC, IPV4_ETHERTYPE, 8'h00, 15);
        send_frame(SHORT_PREAMBLE, NO_BAD_NIBBLE, 1'b0);
        watch_outputs(WATCH_CYCLES, 1, LED_LAST, OFF, OFF, 1'b0, 1'b0);
    endtask

    task automatic check_odd_nibble();
        test_name = "odd_nibble_accept";
        make_frame(DUT_MAC, IPV4_ETHERTYPE, 8'h00, 15);
        send_frame(LONG_PREAMBLE, NO_BAD_NIBBLE, 1'b1);
        watch_outputs(WATCH_CYCLES, LED_FIRST, LED_LAST, OFF, OFF, 1'b0, 1'b0);
        test_name = "odd_nibble_reject";
        make_frame(DUT_MAC, IPV4_ETHERTYPE, 8'h00, 14);    // 14 whole bytes only
        send_frame(LONG_PREAMBLE, NO_BAD_NIBBLE, 1'b1);
        watch_outputs(WATCH_CYCLES, OFF, OFF, OFF, OFF, 1'b0, 1'b0);
    endtask

    initial begin
        rst        = 1'b1;
        phy_rx_dv  = 1'b0;
        phy_rx     = '0;
        lfsr_state = LFSR_SEED;
        test_name  = "reset";
        frame_q.delete();
        repeat (RESET_CYCLES) @(posedge clock_125_mhz_0_deg);
        #1;
        rst = 1'b0;
        check_reset_state();
        check_matching_frame();
        check_rejected_frames();
        check_run_control();
        check_flash_restart();
        check_odd_nibble();
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

/* source/board_pkg.sv */
`default_nettype none

package board_pkg;

    typedef logic [31:0] flash_count_t;    // LED on-time down-counter
    typedef logic [31:0] pattern_word_t;

    // Alternating ones and zeros, cut down to the counter width by the user
    localparam pattern_word_t PATTERN_RESET_VALUE = 32'hAAAA_AAAA;

endpackage

`default_nettype wire

/* source/board_top.sv */
`timescale 1ns/10ps
`default_nettype none

module board_top
    import eth_pkg::*;
    import board_pkg::*;
#(
    parameter mac_addr_t    MAC_ADDR     = 48'h001C_C0A2_22DD,
    parameter flash_count_t FLASH_PERIOD = 32'd10_000_000,
    parameter integer       COUNT_WIDTH  = 32
)
(
    input  wire     clock_125_mhz_0_deg,
    input  wire     rst_i,
    input  wire     phy_rx_dv_i,
    input  nibble_t phy_rx_i,
    output logic    io_led_d2_o,
    output logic    io_led_d3_o,
    output logic    run_o,
    output logic    io_adc_sda_o,
    output logic    io_adc_sda_oe_o,
    output logic    clk_sda1_o,
    output logic    clk_sda1_oe_o,
    output logic    io_sda2_o,
    output logic    io_sda2_oe_o
);

    byte_t       rx_byte;
    logic        rx_byte_valid;
    byte_count_t rx_byte_index;
    logic        rx_frame_end;
    logic        this_mac;

    mii_rx u_mii_rx (
        .clock_125_mhz_0_deg (clock_125_mhz_0_deg),
        .rst_i               (rst_i),
        .rx_dv_i             (phy_rx_dv_i),
        .rx_data_i           (phy_rx_i),
        .rx_byte_o           (rx_byte),
        .rx_byte_valid_o     (rx_byte_valid),
        .rx_byte_index_o     (rx_byte_index),
        .rx_frame_end_o      (rx_frame_end)
    );

    frame_filter #(
        .MAC_ADDR (MAC_ADDR)
    ) u_frame_filter (
        .clock_125_mhz_0_deg (clock_125_mhz_0_deg),
        .rst_i               (rst_i),
        .rx_byte_i           (rx_byte),
        .rx_byte_valid_i     (rx_byte_valid),
        .rx_byte_index_i     (rx_byte_index),
        .rx_frame_end_i      (rx_frame_end),
        .this_mac_o          (this_mac),
        .run_o               (run_o)
    );

    led_flash #(
        .FLASH_PERIOD (FLASH_PERIOD)
    ) flash_this_mac (
        .clock_125_mhz_0_deg (clock_125_mhz_0_deg),
        .rst_i               (rst_i),
        .signal_i            (this_mac),
        .led_o               (io_led_d2_o)
    );

    led_flash #(
        .FLASH_PERIOD (FLASH_PERIOD)
    ) flash_run (
        .clock_125_mhz_0_deg (clock_125_mhz_0_deg),
        .rst_i               (rst_i),
        .signal_i            (run_o),   // Lights on run going high
        .led_o               (io_led_d3_o)
    );

    io_test_pattern #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) u_io_test_pattern (
        .clock_125_mhz_0_deg (clock_125_mhz_0_deg),
        .rst_i               (rst_i),
        .adc_sda_o           (io_adc_sda_o),
        .adc_sda_oe_o        (io_adc_sda_oe_o),
        .clk_sda1_o          (clk_sda1_o),
        .clk_sda1_oe_o       (clk_sda1_oe_o),
        .sda2_o              (io_sda2_o),
        .sda2_oe_o           (io_sda2_oe_o)
    );

endmodule

`default_nettype wire

/* source/eth_pkg.sv */
`default_nettype none

package eth_pkg;

    typedef logic [3:0]  nibble_t;      // MII receive data
    typedef logic [7:0]  byte_t;
    typedef logic [47:0] mac_addr_t;
    typedef logic [15:0] ethertype_t;
    typedef logic [10:0] byte_count_t;  // Byte position after SFD

    // Preamble is 0x55 on the wire, so every nibble reads 5
    localparam nibble_t PREAMBLE_NIBBLE = 4'h5;

    // SFD byte 0xD5, high nibble arrives second
    localparam nibble_t SFD_NIBBLE = 4'hD;

    // Local experimental EtherType used for run control
    localparam ethertype_t RUN_ETHERTYPE = 16'h88B5;

    // Destination, source, type and one command byte
    localparam byte_count_t MIN_HEADER_BYTES = 11'd15;

    // Byte offsets inside the header
    localparam byte_count_t DEST_BYTES     = 11'd6;
    localparam byte_count_t TYPE_HI_INDEX  = 11'd12;
    localparam byte_count_t TYPE_LO_INDEX  = 11'd13;
    localparam byte_count_t COMMAND_INDEX  = 11'd14;

    typedef enum logic [1:0] {
        IDLE,       // Waiting for rx_dv
        PREAMBLE,   // Stripping preamble nibbles until the SFD
        DATA,       // Pairing nibbles into bytes
        DROP        // Bad preamble, wait for rx_dv to fall
    } rx_state_t;

endpackage

`default_nettype wire

/* source/frame_filter.sv */
`timescale 1ns/10ps
`default_nettype none

module frame_filter
    import eth_pkg::*;
#(
    parameter mac_addr_t MAC_ADDR = 48'h001C_C0A2_22DD
)
(
    input  wire         clock_125_mhz_0_deg,
    input  wire         rst_i,
    input  byte_t       rx_byte_i,
    input  wire         rx_byte_valid_i,
    input  byte_count_t rx_byte_index_i,
    input  wire         rx_frame_end_i,
    output logic        this_mac_o,
    output logic        run_o
);

    logic        dest_match;    // Destination bytes so far equal MAC_ADDR
    byte_count_t frame_bytes;
    ethertype_t  ethertype;
    logic        run_cmd;       // Bit 0 of the command byte
    logic        accept;

    // First byte on the wire is the most significant byte of the address
    function automatic byte_t mac_byte(input byte_count_t idx);
        return MAC_ADDR[8 * (5 - int'(idx[2:0])) +: 8];
    endfunction

    always_ff @(posedge clock_125_mhz_0_deg) begin
        if (rst_i) begin
            dest_match  <= 1'b0;
            frame_bytes <= '0;
        end else if (rx_frame_end_i) begin
            dest_match  <= 1'b0;    // Ready for the next frame
            frame_bytes <= '0;
        end else if (rx_byte_valid_i) begin
            if (rx_byte_index_i == '0) begin
                dest_match  <= (rx_byte_i == mac_byte(rx_byte_index_i));
                frame_bytes <= 11'd1;
            end else begin
                if (rx_byte_index_i < DEST_BYTES) begin
                    dest_match <= dest_match && (rx_byte_i == mac_byte(rx_byte_index_i));
                end
                if (frame_bytes != '1) begin
                    frame_bytes <= frame_bytes + 1'b1;
                end
            end
        end
    end

    // Type and command capture
    always_ff @(posedge clock_125_mhz_0_deg) begin
        if (rx_byte_valid_i) begin
            case (rx_byte_index_i)
                TYPE_HI_INDEX: ethertype[15:8] <= rx_byte_i;
                TYPE_LO_INDEX: ethertype[7:0]  <= rx_byte_i;
                COMMAND_INDEX: run_cmd         <= rx_byte_i[0];
                default: ;
            endcase
        end
    end

    assign accept = dest_match && (frame_bytes >= MIN_HEADER_BYTES);

    always_ff @(posedge clock_125_mhz_0_deg) begin
        if (rst_i) begin
            this_mac_o <= 1'b0;
            run_o      <= 1'b0;
        end else begin
            this_mac_o <= rx_frame_end_i && accept;
            if (rx_frame_end_i && accept && ethertype == RUN_ETHERTYPE) begin
                run_o <= run_cmd;
            end
        end
    end

    a_match_after_end : assert property (
        @(posedge clock_125_mhz_0_deg) disable iff (rst_i)
        this_mac_o |-> $past(rx_frame_end_i)
    );

endmodule

`default_nettype wire

/* source/io_test_pattern.sv */
`timescale 1ns/10ps
`default_nettype none

module io_test_pattern
    import board_pkg::*;
#(
    parameter integer COUNT_WIDTH = 32
)
(
    input  wire  clock_125_mhz_0_deg,
    input  wire  rst_i,
    output logic adc_sda_o,
    output logic adc_sda_oe_o,
    output logic clk_sda1_o,
    output logic clk_sda1_oe_o,
    output logic sda2_o,
    output logic sda2_oe_o
);

    localparam logic [COUNT_WIDTH-1:0] RESET_VALUE = COUNT_WIDTH'(PATTERN_RESET_VALUE);

    logic [COUNT_WIDTH-1:0] counter;

    always_ff @(posedge clock_125_mhz_0_deg) begin
        if (rst_i) begin
            counter <= RESET_VALUE;
        end else begin
            counter <= counter + 1'b1;
        end
    end

    // Each line is driven only while its enable bit is set
    assign adc_sda_oe_o  = counter[COUNT_WIDTH-2];
    assign adc_sda_o     = counter[COUNT_WIDTH-3];
    assign clk_sda1_oe_o = counter[COUNT_WIDTH-3];
    assign clk_sda1_o    = counter[COUNT_WIDTH-4];
    assign sda2_oe_o     = counter[COUNT_WIDTH-4];
    assign sda2_o        = counter[COUNT_WIDTH-5];

endmodule

`default_nettype wire

/* source/led_flash.sv */
`timescale 1ns/10ps
`default_nettype none

module led_flash
    import board_pkg::*;
#(
    parameter flash_count_t FLASH_PERIOD = 32'd10_000_000
)
(
    input  wire  clock_125_mhz_0_deg,
    input  wire  rst_i,
    input  wire  signal_i,
    output logic led_o
);

    logic         signal_d;
    flash_count_t count;

    always_ff @(posedge clock_125_mhz_0_deg) begin
        if (rst_i) begin
            signal_d <= 1'b0;
            count    <= '0;
        end else begin
            signal_d <= signal_i;
            if (signal_i && !signal_d) begin
                count <= FLASH_PERIOD;      // Rising edge restarts on-time
            end else if (count != '0) begin
                count <= count - 1'b1;
            end
        end
    end

    assign led_o = (count != '0);

    a_count_in_range : assert property (
        @(posedge clock_125_mhz_0_deg) disable iff (rst_i)
        count <= FLASH_PERIOD
    );

endmodule

`default_nettype wire

/* source/mii_rx.sv */
`timescale 1ns/10ps
`default_nettype none

module mii_rx
    import eth_pkg::*;
(
    input  wire         clock_125_mhz_0_deg,
    input  wire         rst_i,
    input  wire         rx_dv_i,
    input  nibble_t     rx_data_i,
    output byte_t       rx_byte_o,
    output logic        rx_byte_valid_o,
    output byte_count_t rx_byte_index_o,
    output logic        rx_frame_end_o
);

    rx_state_t   state;
    logic        dv_q;          // Registered PHY inputs
    nibble_t     data_q;
    nibble_t     low_nibble;    // First nibble of the byte in progress
    logic        high_next;     // Next nibble completes a byte
    byte_count_t byte_cnt;

    always_ff @(posedge clock_125_mhz_0_deg) begin
        data_q <= rx_data_i;
        if (rst_i) begin
            dv_q <= 1'b0;
        end else begin
            dv_q <= rx_dv_i;
        end
    end

    always_ff @(posedge clock_125_mhz_0_deg) begin
        if (rst_i) begin
            state           <= IDLE;
            high_next       <= 1'b0;
            byte_cnt        <= '0;
            rx_byte_valid_o <= 1'b0;
            rx_frame_end_o  <= 1'b0;
        end else begin
            rx_byte_valid_o <= 1'b0;
            rx_frame_end_o  <= 1'b0;
            case (state)
                IDLE: begin
                    // Only a rise of rx_dv can be seen here
                    if (dv_q) begin
                        state <= (data_q == PREAMBLE_NIBBLE) ? PREAMBLE : DROP;
                    end
                end
                PREAMBLE: begin
                    if (!dv_q) begin
                        state <= IDLE;              // No frame, no end pulse
                    end else if (data_q == SFD_NIBBLE) begin
                        state     <= DATA;
                        high_next <= 1'b0;
                        byte_cnt  <= '0;
                    end else if (data_q != PREAMBLE_NIBBLE) begin
                        state <= DROP;
                    end
                end
                DATA: begin
                    if (!dv_q) begin
                        state          <= IDLE;     // Half byte is dropped
                        rx_frame_end_o <= 1'b1;
                    end else if (!high_next) begin
                        high_next <= 1'b1;
                    end else begin
                        high_next       <= 1'b0;
                        rx_byte_valid_o <= 1'b1;
                        if (byte_cnt != '1) begin
                            byte_cnt <= byte_cnt + 1'b1;   // Saturates
                        end
                    end
                end
                DROP: begin
                    if (!dv_q) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Byte payload
    always_ff @(posedge clock_125_mhz_0_deg) begin
        if (state == DATA && dv_q) begin
            if (!high_next) begin
                low_nibble <= data_q;
            end else begin
                rx_byte_o       <= {data_q, low_nibble};
                rx_byte_index_o <= byte_cnt;
            end
        end
    end

    a_no_byte_in_idle : assert property (
        @(posedge clock_125_mhz_0_deg) disable iff (rst_i)
        rx_byte_valid_o |-> state != IDLE
    );

    a_single_frame_end : assert property (
        @(posedge clock_125_mhz_0_deg) disable iff (rst_i)
        rx_frame_end_o |=> !rx_frame_end_o
    );

endmodule

`default_nettype wire
